// ==== src/log_cfg_pkg.sv ====
// Register map and configuration types for the odometer event logger.
// Imported by the register block and every block that reads the configuration.
`default_nettype none

package log_cfg_pkg;

  localparam int reg_addr_w = 6;                                     // register address width

  // message buffer window, one 16-bit word per address
  localparam logic [reg_addr_w-1:0] msg_base  = 6'h00;               // first message word
  localparam logic [reg_addr_w-1:0] msg_limit = 6'h1B;               // last message word

  // configuration registers
  localparam logic [reg_addr_w-1:0] ctrl_addr    = 6'h20;            // bit 0 is enable
  localparam logic [reg_addr_w-1:0] denoise_addr = 6'h21;            // de-noise length, 8 bits

  localparam logic [7:0] denoise_default = 8'hFF;                    // longest filter after reset

  // configuration fanned out from the register block
  typedef struct packed {
    logic       enable;                                              // 0 holds the datapath cleared
    logic [7:0] denoise_len;                                         // filter needs len+1 samples
  } log_cfg_t;

  // registered write into the message buffer
  typedef struct packed {
    logic        we;                                                 // single-cycle write strobe
    logic [4:0]  addr;                                               // word address in buffer
    logic [15:0] data;                                               // message word
  } msg_wr_t;

endpackage

`default_nettype wire

// ==== src/log_msg_pkg.sv ====
// Record layout of the logger output stream.
// Shared by the message buffer, the packer and the top level.
`default_nettype none

package log_msg_pkg;

  // message part of a record
  localparam int         msg_words     = 28;                         // 56 bytes of message
  localparam logic [4:0] msg_last_addr = 5'd27;                      // read address of last word

  localparam int ts_words = 2;                                       // 32-bit timestamp, hi first

  // header + timestamp + message
  localparam int rec_words = 1 + ts_words + msg_words;

  // upper byte of the header word, identifies the record source
  typedef enum logic [7:0] {
    hdr_odo = 8'hA5                                                  // odometer event
  } hdr_code_e;

  // packer sequencer
  typedef enum logic [2:0] {
    idle,                                                            // waiting for rdy edge
    header,                                                          // code and sequence number
    ts_hi,                                                           // timestamp [31:16]
    ts_lo,                                                           // timestamp [15:0]
    body                                                             // message words
  } pack_state_e;

  // one word of the output stream, no back-pressure
  typedef struct packed {
    logic        valid;                                              // word present this cycle
    logic        last;                                               // final word of a record
    logic [15:0] data;
  } log_word_t;

endpackage

`default_nettype wire

// ==== src/log_regs.sv ====
// Software write port of the logger.
// Splits writes into message buffer writes and the configuration registers.
`timescale 1ns/10ps
`default_nettype none

module log_regs import log_cfg_pkg::*; (
  input  logic                  xclk,
  input  logic                  rst,
  input  logic                  reg_we,                              // single-cycle write strobe
  input  logic [reg_addr_w-1:0] reg_addr,
  input  logic [15:0]           reg_wdata,
  output log_cfg_t              cfg,
  output msg_wr_t               msg_wr
);

  logic                  enable_q;                                   // control bit 0
  logic [7:0]            denoise_q;                                  // filter length
  logic                  msg_we_q;
  logic [4:0]            msg_addr_q;
  logic [15:0]           msg_data_q;
  logic [reg_addr_w-1:0] msg_off;                                    // offset into buffer window
  logic                  in_msg;                                     // address hits the buffer

  // wraps below msg_base, so one compare checks both ends of the window
  assign msg_off = reg_addr - msg_base;
  assign in_msg  = (msg_off <= (msg_limit - msg_base));

  always_ff @(posedge xclk) begin
    if (rst) begin
      enable_q  <= 1'b0;
      denoise_q <= denoise_default;
      msg_we_q  <= 1'b0;
    end else begin
      msg_we_q <= reg_we && in_msg;                                  // delayed with addr/data
      if (reg_we && (reg_addr == ctrl_addr)) begin
        enable_q <= reg_wdata[0];
      end
      if (reg_we && (reg_addr == denoise_addr)) begin
        denoise_q <= reg_wdata[7:0];
      end
    end
  end

  // write payload, qualified by msg_we_q
  always_ff @(posedge xclk) begin
    msg_addr_q <= msg_off[4:0];
    msg_data_q <= reg_wdata;
  end

  assign cfg    = '{enable: enable_q, denoise_len: denoise_q};
  assign msg_wr = '{we: msg_we_q, addr: msg_addr_q, data: msg_data_q};

endmodule

`default_nettype wire

// ==== src/trig_denoise.sv ====
// Trigger input conditioning: 3-stage synchronizer, then a de-noise filter
// that accepts a new level after denoise_len+1 stable samples.
// Emits one-cycle pulses on the filtered leading and trailing edges.
`timescale 1ns/10ps
`default_nettype none

module trig_denoise import log_cfg_pkg::*; (
  input  logic     xclk,
  input  logic     rst,
  input  log_cfg_t cfg,
  input  logic     trig,                                             // asynchronous level
  output logic     rise_pulse,
  output logic     fall_pulse
);

  logic [2:0] sync_q;                                                // stage 2 is the safe one
  logic [7:0] cnt_q;                                                 // samples left before accept
  logic       filt_q;                                                // filtered level
  logic       filt_d;                                                // filt_q one cycle later

  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      sync_q     <= 3'b000;
      cnt_q      <= cfg.denoise_len;
      filt_q     <= 1'b0;
      filt_d     <= 1'b0;
      rise_pulse <= 1'b0;
      fall_pulse <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], trig};

      if (sync_q[2] == filt_q) begin
        cnt_q <= cfg.denoise_len;                                    // glitch gone, start over
      end else if (cnt_q == 8'd0) begin
        filt_q <= sync_q[2];                                         // stable long enough
        cnt_q  <= cfg.denoise_len;
      end else begin
        cnt_q <= cnt_q - 8'd1;
      end

      filt_d     <= filt_q;
      rise_pulse <= filt_q && !filt_d;                               // one cycle after change
      fall_pulse <= !filt_q && filt_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/odo_message.sv ====
// Odometer message buffer.
// Software fills 28 words at any time; the filtered leading edge requests a
// timestamp and rewinds the reader, the trailing edge flags the message ready.
`timescale 1ns/10ps
`default_nettype none

module odo_message
  import log_cfg_pkg::*;
  import log_msg_pkg::*;
(
  input  logic        xclk,
  input  logic        rst,
  input  log_cfg_t    cfg,
  input  msg_wr_t     msg_wr,
  input  logic        rise_pulse,                                    // filtered leading edge
  input  logic        fall_pulse,                                    // filtered trailing edge
  input  logic        rd_stb,                                        // word taken, advance
  output logic        ts_req,                                        // latch the timestamp
  output logic        rdy,                                           // message waiting
  output logic [15:0] rdata
);

  logic [15:0] buf_mem [0:31];                                       // only 0..27 are written
  logic [4:0]  raddr;
  logic        last_rd;                                              // reading final word

  // write side runs regardless of enable
  always_ff @(posedge xclk) begin
    if (msg_wr.we) begin
      buf_mem[msg_wr.addr] <= msg_wr.data;
    end
  end

  // asynchronous read, so a same-cycle write to raddr still shows the old word
  assign rdata = buf_mem[raddr];

  assign last_rd = rd_stb && (raddr == msg_last_addr);

  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      ts_req <= 1'b0;
    end else begin
      ts_req <= rise_pulse;
    end
  end

  // read pointer, rewound on every new event
  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      raddr <= 5'd0;
    end else if (ts_req) begin
      raddr <= 5'd0;
    end else if (rd_stb) begin
      raddr <= raddr + 5'd1;
    end
  end

  // ready from trailing edge until the last word is read
  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      rdy <= 1'b0;
    end else if (ts_req || last_rd) begin
      rdy <= 1'b0;                                                   // new event or drained
    end else if (fall_pulse) begin
      rdy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/timestamp_counter.sv ====
// Event timestamp source.
// Free-running count of enabled xclk cycles, sampled on each timestamp request.
`timescale 1ns/10ps
`default_nettype none

module timestamp_counter import log_cfg_pkg::*; (
  input  logic        xclk,
  input  logic        rst,
  input  log_cfg_t    cfg,
  input  logic        ts_req,                                        // single-cycle sample strobe
  output logic [31:0] ts_value                                       // last sampled count
);

  logic [31:0] cnt_q;

  // wraps after 2^32 cycles
  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      cnt_q <= 32'd0;
    end else begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  // holds until the next request
  always_ff @(posedge xclk) begin
    if (ts_req) begin
      ts_value <= cnt_q;                                             // count of the req cycle
    end
  end

endmodule

`default_nettype wire

// ==== src/log_packer.sv ====
// Record sequencer for the output stream.
// On each new ready message sends header, timestamp hi/lo and the 28 message
// words back to back, one word per cycle, last flagged on the final word.
`timescale 1ns/10ps
`default_nettype none

module log_packer
  import log_cfg_pkg::*;
  import log_msg_pkg::*;
(
  input  logic        xclk,
  input  logic        rst,
  input  log_cfg_t    cfg,
  input  logic        ts_req,                                        // new event, drop pending start
  input  logic        rdy,
  input  logic [15:0] rdata,
  input  logic [31:0] ts_value,
  output logic        rd_stb,                                        // one buffer word per cycle
  output log_word_t   log_out
);

  pack_state_e state;
  logic        rdy_q;                                                // for rdy edge detect
  logic [7:0]  seq;                                                  // record sequence number
  logic [4:0]  wcnt;                                                 // index of next word out
  logic        out_valid;
  logic        out_last;
  logic [15:0] out_data;
  logic        rec_end;                                              // final body word this cycle

  assign rd_stb  = (state == body);
  assign rec_end = (state == body) && (wcnt == 5'(rec_words - 1));

  always_ff @(posedge xclk) begin
    if (rst || !cfg.enable) begin
      state     <= idle;
      rdy_q     <= 1'b0;
      seq       <= 8'd0;
      wcnt      <= 5'd0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      rdy_q     <= rdy;
      out_valid <= (state != idle) && !(state == header && ts_req);
      out_last  <= rec_end;
      unique case (state)
        idle: begin
          wcnt <= 5'd0;
          if (rdy && !rdy_q) state <= header;                        // rising edge of rdy only
        end
        header: begin
          wcnt  <= wcnt + 5'd1;
          state <= ts_req ? idle : ts_hi;                            // restarted before output
        end
        ts_hi: begin
          wcnt  <= wcnt + 5'd1;
          state <= ts_lo;
        end
        ts_lo: begin
          wcnt  <= wcnt + 5'd1;
          state <= body;
        end
        body: begin
          wcnt <= wcnt + 5'd1;
          if (rec_end) begin
            seq   <= seq + 8'd1;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // word payload, qualified by out_valid
  always_ff @(posedge xclk) begin
    case (state)
      header:  out_data <= {hdr_odo, seq};
      ts_hi:   out_data <= ts_value[31:16];
      ts_lo:   out_data <= ts_value[15:0];
      body:    out_data <= rdata;                                    // word at raddr before rd_stb
      default: out_data <= out_data;
    endcase
  end

  assign log_out = '{valid: out_valid, last: out_last, data: out_data};

endmodule

`default_nettype wire

// ==== src/imu_logger_top.sv ====
// Odometer event logger top level.
// Software writes the message and config, the trig input marks the event,
// records leave on log_out one word per cycle with no back-pressure.
`timescale 1ns/10ps
`default_nettype none

module imu_logger_top
  import log_cfg_pkg::*;
  import log_msg_pkg::*;
(
  input  logic                  xclk,
  input  logic                  rst,
  input  logic                  reg_we,
  input  logic [reg_addr_w-1:0] reg_addr,
  input  logic [15:0]           reg_wdata,
  input  logic                  trig,                                // asynchronous level
  output log_word_t             log_out
);

  log_cfg_t    cfg;                                                  // to every block
  msg_wr_t     msg_wr;
  logic        rise_pulse;
  logic        fall_pulse;
  logic        ts_req;
  logic        rdy;
  logic [15:0] rdata;
  logic        rd_stb;
  logic [31:0] ts_value;

  log_regs log_regs_i (
    .xclk(xclk), .rst(rst), .reg_we(reg_we), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .cfg(cfg), .msg_wr(msg_wr)
  );

  trig_denoise trig_denoise_i (
    .xclk(xclk), .rst(rst), .cfg(cfg), .trig(trig),
    .rise_pulse(rise_pulse), .fall_pulse(fall_pulse)
  );

  odo_message odo_message_i (
    .xclk(xclk), .rst(rst), .cfg(cfg), .msg_wr(msg_wr),
    .rise_pulse(rise_pulse), .fall_pulse(fall_pulse), .rd_stb(rd_stb),
    .ts_req(ts_req), .rdy(rdy), .rdata(rdata)
  );

  timestamp_counter timestamp_counter_i (
    .xclk(xclk), .rst(rst), .cfg(cfg), .ts_req(ts_req), .ts_value(ts_value)
  );

  log_packer log_packer_i (
    .xclk(xclk), .rst(rst), .cfg(cfg), .ts_req(ts_req), .rdy(rdy),
    .rdata(rdata), .ts_value(ts_value), .rd_stb(rd_stb), .log_out(log_out)
  );

endmodule

`default_nettype wire

// ==== sim/imu_logger_tb.sv ====
// Table-driven testbench for the odometer event logger.
// Each table entry runs one trigger event and checks the record on log_out.
`timescale 1ns/10ps
`default_nettype none

module imu_logger_tb
  import log_cfg_pkg::*;
  import log_msg_pkg::*;
();

  localparam int clk_period   = 40;                                  // ns
  localparam int reset_cycles = 16;
  localparam int n_tests      = 6;
  localparam int rec_timeout  = 4 * 256;                             // cycles to wait for last
  localparam int quiet_window = 200;                                 // no-record window

  // one row of the stimulus table
  typedef struct packed {
    logic [7:0] hi_cycles;                                           // trig high time
    logic       pre_write;                                           // new message before trig
    logic       mid_write;                                           // rewrite while trig high
    logic       enable;
    logic       reenable;                                            // pulse enable low first
    logic       expect_rec;
    logic       check_ts;                                            // compare with last record
    logic [7:0] exp_seq;
  } test_entry_t;

  logic                  xclk;
  logic                  rst;
  logic                  reg_we;
  logic [reg_addr_w-1:0] reg_addr;
  logic [15:0]           reg_wdata;
  logic                  trig;
  log_word_t             log_out;

  test_entry_t tests [$];
  logic [15:0] exp_msg [$];                                          // model of the buffer
  logic [15:0] rec_data [$];                                         // every word seen on log_out
  logic        rec_last [$];
  int          last_total = 0;                                       // records ended so far
  int          cyc = 0;
  int          errors = 0;
  int          tests_failed = 0;
  int          test_err;
  logic [31:0] prev_ts = 32'd0;
  int          prev_rise = 0;
  int          rise_cyc;

  imu_logger_top imu_logger_top_i (
    .xclk(xclk), .rst(rst), .reg_we(reg_we), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .trig(trig), .log_out(log_out)
  );

  initial begin
    xclk = 1'b0;
    forever #(clk_period / 2) xclk = ~xclk;
  end

  always @(posedge xclk) cyc <= cyc + 1;                             // tb cycle count

  // collects output words as sampled before the edge updates them
  always @(posedge xclk) begin
    if (log_out.valid) begin
      rec_data.push_back(log_out.data);
      rec_last.push_back(log_out.last);
      if (log_out.last) last_total <= last_total + 1;
    end
  end

  initial begin
    repeat (n_tests * (4 * 256 + 64)) @(posedge xclk);
    $display("watchdog expired: the tests did not finish in the expected time");
    $display("TB FAILED");
    $finish;
  end

  function automatic test_entry_t entry(input int hi, input bit pre, input bit mid,
                                        input bit en, input bit reen, input bit rec,
                                        input bit tsc, input int seq);
    test_entry_t e;
    e.hi_cycles  = 8'(hi);
    e.pre_write  = pre;
    e.mid_write  = mid;
    e.enable     = en;
    e.reenable   = reen;
    e.expect_rec = rec;
    e.check_ts   = tsc;
    e.exp_seq    = 8'(seq);
    return e;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge xclk);
  endtask

  task automatic reg_write(input logic [reg_addr_w-1:0] addr, input logic [15:0] data);
    @(posedge xclk);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge xclk);
    reg_we    <= 1'b0;
  endtask

  // 28 random words on consecutive cycles plus one idle edge
  task automatic write_message();
    logic [15:0] w;
    for (int i = 0; i < msg_words; i++) begin
      w = 16'($urandom);
      @(posedge xclk);
      reg_we     <= 1'b1;
      reg_addr   <= msg_base + 6'(i);
      reg_wdata  <= w;
      exp_msg[i] = w;
    end
    @(posedge xclk);
    reg_we <= 1'b0;
  endtask

  task automatic check_value(input string what, input int idx,
                             input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s word %0d is %h, expected %h",
               $time, what, idx, got, exp);
      test_err++;
    end
  endtask

  // waits a bounded time for the packer's last flag
  task automatic wait_record(input int last_base, output bit got);
    int n;
    n = 0;
    while (last_total == last_base && n < rec_timeout) begin
      @(posedge xclk);
      n++;
    end
    got = (last_total > last_base);
  endtask

  task automatic check_record(input int base, input test_entry_t e);
    int          nwords;
    logic [31:0] ts;
    nwords = rec_data.size() - base;
    if (nwords != 31) begin
      $display("CHECK FAILED at %0t: record has %0d words, expected 31", $time, nwords);
      test_err++;
      return;
    end
    for (int k = 0; k < 31; k++) begin
      if (rec_last[base + k] !== (k == 30)) begin                    // last only on word 31
        $display("CHECK FAILED at %0t: last flag wrong on word %0d", $time, k);
        test_err++;
      end
    end
    check_value("header", 0, rec_data[base], {8'hA5, e.exp_seq});
    for (int k = 0; k < 28; k++) begin
      check_value("body", k, rec_data[base + 3 + k], exp_msg[k]);
    end
    ts = {rec_data[base + 1], rec_data[base + 2]};                   // hi word first
    if (e.check_ts) begin
      if (!(ts > prev_ts) || (ts - prev_ts) < 32'(rise_cyc - prev_rise - 16)) begin
        $display("CHECK FAILED at %0t: timestamp %h after %h, rises %0d cycles apart",
                 $time, ts, prev_ts, rise_cyc - prev_rise);
        test_err++;
      end
    end
    prev_ts   = ts;
    prev_rise = rise_cyc;
  endtask

  task automatic run_test(input int idx, input test_entry_t e);
    int rec_base;
    int last_base;
    int hi_left;
    bit got;
    test_err = 0;
    if (e.reenable) begin
      reg_write(ctrl_addr, 16'h0000);                                // clears seq and datapath
      wait_cycles(4);
    end
    reg_write(ctrl_addr, {15'd0, e.enable});
    if (e.pre_write) write_message();
    wait_cycles(4);
    rec_base  = rec_data.size();
    last_base = last_total;
    @(posedge xclk);
    trig     <= 1'b1;
    rise_cyc = cyc;
    hi_left  = int'(e.hi_cycles);
    if (e.mid_write) begin
      write_message();                                               // lands before the fall
      hi_left -= msg_words + 1;
    end
    wait_cycles(hi_left);
    trig <= 1'b0;
    if (e.expect_rec) begin
      wait_record(last_base, got);
      wait_cycles(8);                                                // catch trailing words
      if (!got) begin
        $display("test %0d: no record arrived within %0d cycles", idx, rec_timeout);
        test_err++;
      end else begin
        check_record(rec_base, e);
      end
    end else begin
      wait_cycles(quiet_window);
      if (rec_data.size() != rec_base) begin
        $display("CHECK FAILED at %0t: %0d unexpected words on log_out",
                 $time, rec_data.size() - rec_base);
        test_err++;
      end
    end
    wait_cycles(16);
    $display("test %0d (trig %0d cycles, record %0s): %0s", idx, e.hi_cycles,
             e.expect_rec ? "expected" : "not expected", (test_err == 0) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(32'hac439a9a));
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = 16'h0000;
    trig      = 1'b0;
    for (int i = 0; i < msg_words; i++) exp_msg.push_back(16'h0000);

    //                     hi  pre mid en reen rec ts seq
    tests.push_back(entry(40, 0,  0,  0, 0,   0,  0, 0));           // disabled so nothing out
    tests.push_back(entry(40, 1,  0,  1, 0,   1,  0, 0));           // first record
    tests.push_back(entry(4,  0,  0,  1, 0,   0,  0, 0));           // short glitch filtered out
    tests.push_back(entry(40, 1,  0,  1, 0,   1,  1, 1));           // second record with later ts
    tests.push_back(entry(48, 0,  1,  1, 0,   1,  0, 2));           // rewrite while high
    tests.push_back(entry(40, 1,  0,  1, 1,   1,  0, 0));           // seq restarts

    repeat (reset_cycles) @(posedge xclk);
    rst <= 1'b0;
    reg_write(denoise_addr, 16'd8);                                  // 9 stable samples

    for (int i = 0; i < tests.size(); i++) begin
      run_test(i, tests[i]);
      if (test_err != 0) begin
        errors += test_err;
        tests_failed++;
      end
    end

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests.size(), tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/log_cfg_pkg.sv
src/log_msg_pkg.sv
src/log_regs.sv
src/trig_denoise.sv
src/odo_message.sv
src/timestamp_counter.sv
src/log_packer.sv
src/imu_logger_top.sv
sim/imu_logger_tb.sv

// ==== Makefile ====
# Verilator flow for the odometer event logger

TOP := imu_logger_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/10ps \
		--top-module $(TOP) -f verilog.f

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
